// ==== hdl/km_pkg.sv ====
////////////////////////////////////////
// Widths for the Karatsuba multiplier.
// Operands are unsigned and OP_W must be even.
// The project is built at a single width.
////////////////////////////////////////
`default_nettype none

package km_pkg;

  localparam int OP_W   = 64;         // Operand width
  localparam int HALF_W = OP_W / 2;   // One half of an operand
  localparam int PROD_W = 2 * OP_W;   // Full product
  localparam int TAG_W  = 8;          // Request tag carried alongside each pair
  localparam int LAT    = 3;          // Decode, execute and result

  // Middle term needs two extra bits for the sum and the signed correction
  localparam int MID_W  = 2 * HALF_W + 2;

  typedef logic [OP_W-1:0]     op_t;
  typedef logic [HALF_W-1:0]   half_t;
  typedef logic [2*HALF_W-1:0] pp_t;   // Half by half partial product
  typedef logic [MID_W-1:0]    mid_t;
  typedef logic [PROD_W-1:0]   prod_t;
  typedef logic [TAG_W-1:0]    tag_t;

endpackage

`default_nettype wire

// ==== hdl/km_dec_if.sv ====
////////////////////////////////////////
// Decode to execute payload.
// Holds the operand halves, the absolute
// half differences and the middle sign.
// All fields move together on advance.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface km_dec_if import km_pkg::*; ();

  half_t hi_a;    // Upper half of operand a
  half_t lo_a;    // Lower half of operand a
  half_t hi_b;
  half_t lo_b;
  half_t dif_a;   // Distance between lo_a and hi_a
  half_t dif_b;   // Distance between hi_b and lo_b
  logic  neg;     // Product of the differences is subtracted

  // Decode side writes the registered values
  modport dec (
    output hi_a,
    output lo_a,
    output hi_b,
    output lo_b,
    output dif_a,
    output dif_b,
    output neg
  );

  modport exe (
    input hi_a,
    input lo_a,
    input hi_b,
    input lo_b,
    input dif_a,
    input dif_b,
    input neg
  );

endinterface

`default_nettype wire

// ==== hdl/km_exe_if.sv ====
////////////////////////////////////////
// Execute to result payload.
// Three half width products plus the sign
// of the difference product.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface km_exe_if import km_pkg::*; ();

  pp_t  p_hi;    // hi_a * hi_b
  pp_t  p_lo;    // lo_a * lo_b
  pp_t  p_dif;   // dif_a * dif_b, magnitude only
  logic neg;

  modport exe (
    output p_hi,
    output p_lo,
    output p_dif,
    output neg
  );

  // Result stage only reads
  modport res (
    input p_hi,
    input p_lo,
    input p_dif,
    input neg
  );

endinterface

`default_nettype wire

// ==== hdl/km_pipe_ctrl.sv ====
////////////////////////////////////////
// Valid and tag tracking for the pipeline.
// The whole pipe moves as one unit, so a
// stall at the output freezes every stage.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module km_pipe_ctrl import km_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_val,
  input  tag_t i_tag,
  input  logic i_rdy,
  output logic o_adv,
  output logic o_val,
  output tag_t o_tag
);

  logic [LAT-1:0] val_q;   // Bit 0 follows decode, top bit follows result
  tag_t [LAT-1:0] tag_q;

  assign o_val = val_q[LAT-1];
  assign o_tag = tag_q[LAT-1];

  // Advance when the output slot is empty or is being drained this cycle
  assign o_adv = !o_val || i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= '0;
    end else if (o_adv) begin
      val_q <= {val_q[LAT-2:0], i_val};   // Bubbles shift in as zeros
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_adv) begin
      tag_q <= {tag_q[LAT-2:0], i_tag};
    end
  end

  // A stalled result must be presented unchanged until it is taken
  a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_tag)))
    else $error("result valid or tag changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/km_decode.sv ====
////////////////////////////////////////
// Stage 1 of the multiplier.
// Splits both operands in half and forms
// the absolute half differences and the
// sign of the middle correction term.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module km_decode import km_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_adv,
  input  op_t       i_a,
  input  op_t       i_b,
  km_dec_if.dec     dec_o
);

  half_t hi_a;
  half_t lo_a;
  half_t hi_b;
  half_t lo_b;
  logic  a_lt;   // lo_a below hi_a, so (lo_a - hi_a) is negative
  logic  b_lt;   // hi_b below lo_b, so (hi_b - lo_b) is negative

  assign hi_a = i_a[OP_W-1 -: HALF_W];
  assign lo_a = i_a[HALF_W-1:0];
  assign hi_b = i_b[OP_W-1 -: HALF_W];
  assign lo_b = i_b[HALF_W-1:0];

  assign a_lt = lo_a < hi_a;
  assign b_lt = hi_b < lo_b;

  // The middle term is hi*hi + lo*lo + (lo_a - hi_a)(hi_b - lo_b)
  always_ff @(posedge i_clk) begin
    if (i_adv) begin
      dec_o.hi_a  <= hi_a;
      dec_o.lo_a  <= lo_a;
      dec_o.hi_b  <= hi_b;
      dec_o.lo_b  <= lo_b;
      dec_o.dif_a <= a_lt ? hi_a - lo_a : lo_a - hi_a;
      dec_o.dif_b <= b_lt ? lo_b - hi_b : hi_b - lo_b;
      // Difference product is negative when exactly one factor is
      dec_o.neg   <= a_lt ^ b_lt;
    end
  end

  // Equal halves must give a zero difference, whatever sign is chosen
  a_dif_a_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (dec_o.hi_a == dec_o.lo_a) |-> (dec_o.dif_a == '0))
    else $error("dif_a nonzero for equal halves of a");

  a_dif_b_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (dec_o.hi_b == dec_o.lo_b) |-> (dec_o.dif_b == '0))
    else $error("dif_b nonzero for equal halves of b");

endmodule

`default_nettype wire

// ==== hdl/km_execute.sv ====
////////////////////////////////////////
// Stage 2 of the multiplier.
// Three native half width multiplies, one
// register stage deep. neg rides along.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module km_execute import km_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_adv,
  km_dec_if.exe dec_i,
  km_exe_if.exe exe_o
);

  pp_t p_hi;
  pp_t p_lo;
  pp_t p_dif;

  // Operands widened first so each product keeps all of its bits
  assign p_hi  = pp_t'(dec_i.hi_a) * pp_t'(dec_i.hi_b);
  assign p_lo  = pp_t'(dec_i.lo_a) * pp_t'(dec_i.lo_b);
  assign p_dif = pp_t'(dec_i.dif_a) * pp_t'(dec_i.dif_b);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      exe_o.p_hi  <= '0;
      exe_o.p_lo  <= '0;
      exe_o.p_dif <= '0;
      exe_o.neg   <= 1'b0;
    end else if (i_adv) begin
      exe_o.p_hi  <= p_hi;
      exe_o.p_lo  <= p_lo;
      exe_o.p_dif <= p_dif;   // Magnitude only, sign is applied in result
      exe_o.neg   <= dec_i.neg;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/km_result.sv ====
////////////////////////////////////////
// Stage 3 of the multiplier.
// Recombines the three partial products:
// p_hi << OP_W + mid << HALF_W + p_lo.
// o_prod changes only on advance.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module km_result import km_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_adv,
  km_exe_if.res exe_i,
  output prod_t o_prod
);

  mid_t  sum_hl;   // p_hi + p_lo, at most one bit over pp_t
  mid_t  mid;      // Equals hi_a*lo_b + lo_a*hi_b
  prod_t prod;

  assign sum_hl = mid_t'(exe_i.p_hi) + mid_t'(exe_i.p_lo);

  // Subtracting can wrap only if the partial products are inconsistent
  assign mid = exe_i.neg ? sum_hl - mid_t'(exe_i.p_dif)
                         : sum_hl + mid_t'(exe_i.p_dif);

  always_comb begin
    prod = (prod_t'(exe_i.p_hi) << OP_W)
         + (prod_t'(mid) << HALF_W)
         + prod_t'(exe_i.p_lo);
  end

  always_ff @(posedge i_clk) begin
    if (i_adv) begin
      o_prod <= prod;
    end
  end

  // A true middle term is below 2**(MID_W-1), so the top bit flags a wrap
  a_mid_nonneg: assert property (@(posedge i_clk) disable iff (i_rst)
    !mid[MID_W-1])
    else $error("middle term went negative, neg or p_dif out of step");

endmodule

`default_nettype wire

// ==== hdl/karatsuba_mult_top.sv ====
////////////////////////////////////////
// Pipelined Karatsuba unsigned multiplier.
// Latency is LAT stages, one pair per cycle.
// Accept on i_val && o_rdy, drain on
// o_val && i_rdy. Results leave in order.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module karatsuba_mult_top import km_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  op_t   i_a,
  input  op_t   i_b,
  input  logic  i_val,
  input  tag_t  i_tag,
  input  logic  i_rdy,
  output logic  o_rdy,
  output logic  o_val,
  output tag_t  o_tag,
  output prod_t o_prod
);

  km_dec_if u_dec_if ();
  km_exe_if u_exe_if ();

  // o_rdy doubles as the global advance for every stage
  km_pipe_ctrl u_ctrl (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (i_val),
    .i_tag (i_tag),
    .i_rdy (i_rdy),
    .o_adv (o_rdy),
    .o_val (o_val),
    .o_tag (o_tag)
  );

  km_decode u_decode (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_adv (o_rdy),
    .i_a   (i_a),
    .i_b   (i_b),
    .dec_o (u_dec_if.dec)
  );

  km_execute u_execute (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_adv (o_rdy),
    .dec_i (u_dec_if.exe),
    .exe_o (u_exe_if.exe)
  );

  km_result u_result (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_adv  (o_rdy),
    .exe_i  (u_exe_if.res),
    .o_prod (o_prod)
  );

endmodule

`default_nettype wire

// ==== verif/karatsuba_mult_tb.sv ====
////////////////////////////////////////
// Directed testbench for the Karatsuba multiplier.
// Expected products come from native 128 bit
// multiplication. Outputs are sampled on the
// falling edge and inputs move 1 ns after rising.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module karatsuba_mult_tb import km_pkg::*; ();

  localparam int SEED    = 77443;
  localparam int LATENCY = 3;      // Cycles from accept to result with i_rdy held high
  localparam int MAX_CYC = 2000;

  logic  i_clk = 1'b0;
  logic  i_rst, i_val, i_rdy, o_rdy, o_val;
  op_t   i_a, i_b;
  tag_t  i_tag, o_tag, tag_ctr;
  prod_t o_prod;

  prod_t prod_q[$];   // Expected results in request order
  tag_t  tag_q[$];
  int    cyc_q[$];    // Cycle of each accept
  int    cyc = 0;
  int    errors = 0;
  int    checks = 0;
  logic  stall_en = 1'b0;
  logic  chk_lat = 1'b0;
  logic  held = 1'b0;
  prod_t held_prod;
  tag_t  held_tag;

  karatsuba_mult_top u_dut (
    .i_clk (i_clk), .i_rst (i_rst), .i_a (i_a), .i_b (i_b), .i_val (i_val),
    .i_tag (i_tag), .i_rdy (i_rdy), .o_rdy (o_rdy), .o_val (o_val),
    .o_tag (o_tag), .o_prod (o_prod)
  );

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("ERROR: timeout after %0d cycles, results stopped draining", cyc);
      $display("sim failed");
      $finish;
    end
  end

  // Drives i_rdy at random while stalls are enabled and high otherwise
  initial begin
    i_rdy = 1'b1;
    forever begin
      @(posedge i_clk);
      #1;
      i_rdy = stall_en ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  task automatic check(input string name, input prod_t got, input prod_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Sees the handshakes that the next rising edge will complete
  always @(negedge i_clk) begin
    if (!i_rst) begin
      check("o_rdy", prod_t'(o_rdy), prod_t'(!(o_val && !i_rdy)));
      if (held) begin
        check("o_prod", o_prod, held_prod);   // Must not move while stalled
        check("o_tag", prod_t'(o_tag), prod_t'(held_tag));
      end
      held = o_val && !i_rdy;
      held_prod = o_prod;
      held_tag = o_tag;
      if (o_val && i_rdy) begin
        if (prod_q.size() == 0) begin
          $display("ERROR t=%0t: result presented with no request outstanding", $time);
          errors++;
        end else begin
          check("o_prod", o_prod, prod_q.pop_front());
          check("o_tag", prod_t'(o_tag), prod_t'(tag_q.pop_front()));
          if (chk_lat)
            check("latency", prod_t'(cyc - cyc_q.pop_front()), prod_t'(LATENCY));
          else
            void'(cyc_q.pop_front());
        end
      end
      if (i_val && o_rdy) begin
        prod_q.push_back(prod_t'(i_a) * prod_t'(i_b));
        tag_q.push_back(i_tag);
        cyc_q.push_back(cyc);
      end
    end
  end

  task automatic send(input op_t a, input op_t b);
    logic taken;
    i_a = a;
    i_b = b;
    i_tag = tag_ctr;
    i_val = 1'b1;
    do begin
      @(negedge i_clk);
      taken = o_rdy;
      @(posedge i_clk);
      #1;
    end while (!taken);
    i_val = 1'b0;
    tag_ctr++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic drain();
    while (prod_q.size() != 0) @(posedge i_clk);
    #1;
    idle(2);
  endtask

  task automatic test_reset();
    @(negedge i_clk);
    check("o_val", prod_t'(o_val), '0);
    check("o_rdy", prod_t'(o_rdy), prod_t'(1));
  endtask

  // Equal halves give zero differences and the last three pairs cover both neg values
  task automatic test_corners();
    chk_lat = 1'b1;
    send(64'h0, 64'h0);
    send(64'h1, 64'h1);
    send('1, '1);
    send('1, 64'h1);
    send(64'h1234_5678_1234_5678, 64'h9abc_def0_9abc_def0);
    send(64'hffff_0000_0000_ffff, 64'h0000_ffff_ffff_0000);
    send(64'h8000_0001_0000_0001, 64'h0000_0001_ffff_fffe);
    send(64'h0000_0001_8000_0000, 64'h0000_0001_ffff_fffe);
    send(64'hffff_ffff_0000_0000, 64'hffff_ffff_0000_0000);
    drain();
  endtask

  task automatic test_stream();
    chk_lat = 1'b1;
    repeat (200) send({$urandom, $urandom}, {$urandom, $urandom});
    drain();
  endtask

  task automatic test_backpressure();
    chk_lat = 1'b0;   // Stalls stretch the latency
    stall_en = 1'b1;
    repeat (150) send({$urandom, $urandom}, {$urandom, $urandom});
    stall_en = 1'b0;
    drain();
  endtask

  task automatic test_bubbles();
    chk_lat = 1'b1;
    repeat (60) begin
      send({$urandom, $urandom}, {$urandom, $urandom});
      idle($urandom_range(0, 3));
    end
    drain();
  endtask

  initial begin
    void'($urandom(SEED));
    i_rst = 1'b1;
    i_val = 1'b0;
    i_a = '0;
    i_b = '0;
    i_tag = '0;
    tag_ctr = '0;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    test_reset();
    test_corners();
    test_stream();
    test_backpressure();
    test_bubbles();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== karatsuba_mult_top.f ====
hdl/km_pkg.sv
hdl/km_dec_if.sv
hdl/km_exe_if.sv
hdl/km_pipe_ctrl.sv
hdl/km_decode.sv
hdl/km_execute.sv
hdl/km_result.sv
hdl/karatsuba_mult_top.sv
verif/karatsuba_mult_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module karatsuba_mult_tb \
		-f karatsuba_mult_top.f
	out="$$(./obj_dir/Vkaratsuba_mult_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
